// ==== common/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD  = 3'b000; // Also sub when alt is set on OP.
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // Srl, or sra when alt is set.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fields_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fields_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        s_fields_t s;
        b_fields_t b;
        u_fields_t u;
        j_fields_t j;
    } instr_word_u;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_LOAD,
        CLS_STORE,
        CLS_NONE
    } op_class_e;

endpackage

// ==== common/core_ifs.sv ====
`timescale 1ns/1ps

interface exec_if;
    logic                     valid;
    logic                     ready;
    rv_pkg::op_class_e        op_class;
    logic [2:0]               funct3;
    logic                     alt;      // Bit 30 of the instruction word.
    logic [rv_pkg::XLEN-1:0]  pc;
    logic [rv_pkg::XLEN-1:0]  rs1_val;
    logic [rv_pkg::XLEN-1:0]  rs2_val;
    logic [rv_pkg::XLEN-1:0]  imm;
    logic [4:0]               rd;

    modport decode (output valid, op_class, funct3, alt, pc, rs1_val, rs2_val, imm, rd,
                    input ready);
    modport exec (input valid, op_class, funct3, alt, pc, rs1_val, rs2_val, imm, rd,
                  output ready);
endinterface

interface mem_if;
    logic                     req;
    logic                     we;
    logic [rv_pkg::XLEN-1:0]  addr;
    logic [rv_pkg::XLEN-1:0]  wdata;
    logic                     done;
    logic [rv_pkg::XLEN-1:0]  rdata;

    modport master (output req, we, addr, wdata, input done, rdata);
    modport slave (input req, we, addr, wdata, output done, rdata);
endinterface

interface retire_if;
    logic                     valid;
    logic [4:0]               rd;
    logic [rv_pkg::XLEN-1:0]  value;
    logic [rv_pkg::XLEN-1:0]  next_pc;

    modport source (output valid, rd, value, next_pc);
    modport sink (input valid, rd, value, next_pc);
endinterface

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [4:0]               rs1_addr,
    input  logic [4:0]               rs2_addr,
    output logic [rv_pkg::XLEN-1:0]  rs1_val,
    output logic [rv_pkg::XLEN-1:0]  rs2_val,
    retire_if.sink                   retire
);

    logic [rv_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid && retire.rd != 5'd0) begin
            regs[retire.rd] <= retire.value;
        end
    end

    assign rs1_val = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== decode/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [rv_pkg::XLEN-1:0]  fetch_pc,
    input  logic [rv_pkg::XLEN-1:0]  instr,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    exec_if.decode                   exe,
    retire_if.sink                   retire
);

    typedef enum logic [1:0] {S_RESET, S_IDLE, S_BUSY} state_e;

    state_e                   state;
    logic [rv_pkg::XLEN-1:0]  pc;
    logic                     accept;
    rv_pkg::instr_word_u      word;
    rv_pkg::op_class_e        cls;
    logic [rv_pkg::XLEN-1:0]  imm;
    logic [rv_pkg::XLEN-1:0]  rs1_val;
    logic [rv_pkg::XLEN-1:0]  rs2_val;

    assign word        = instr;
    assign fetch_pc    = pc;
    assign instr_ready = (state == S_IDLE);
    assign accept      = instr_valid && instr_ready;

    always_comb begin
        case (word.r.opcode)
            rv_pkg::OPC_LUI:    cls = rv_pkg::CLS_LUI;
            rv_pkg::OPC_AUIPC:  cls = rv_pkg::CLS_AUIPC;
            rv_pkg::OPC_JAL:    cls = rv_pkg::CLS_JAL;
            rv_pkg::OPC_JALR:   cls = rv_pkg::CLS_JALR;
            rv_pkg::OPC_BRANCH: cls = rv_pkg::CLS_BRANCH;
            rv_pkg::OPC_OP_IMM: cls = rv_pkg::CLS_ALU_IMM;
            rv_pkg::OPC_OP:     cls = rv_pkg::CLS_ALU_REG;
            rv_pkg::OPC_LOAD:   cls = rv_pkg::CLS_LOAD;
            rv_pkg::OPC_STORE:  cls = rv_pkg::CLS_STORE;
            default:            cls = rv_pkg::CLS_NONE;
        endcase
    end

    always_comb begin
        case (cls)
            rv_pkg::CLS_LUI, rv_pkg::CLS_AUIPC:
                imm = {word.u.imm_31_12, 12'b0};
            rv_pkg::CLS_JAL:
                imm = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                       word.j.imm_11, word.j.imm_10_1, 1'b0};
            rv_pkg::CLS_BRANCH:
                imm = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                       word.b.imm_10_5, word.b.imm_4_1, 1'b0};
            rv_pkg::CLS_STORE:
                imm = {{20{word.s.imm_11_5[6]}}, word.s.imm_11_5, word.s.imm_4_0};
            rv_pkg::CLS_ALU_REG, rv_pkg::CLS_NONE:
                imm = '0;
            default:
                imm = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
        endcase
    end

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (word.r.rs1),
        .rs2_addr (word.r.rs2),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .retire   (retire)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= S_RESET;
            pc        <= RESET_PC;
            exe.valid <= 1'b0;
        end else begin
            case (state)
                S_RESET: state <= S_IDLE;
                S_IDLE: begin
                    if (accept) begin
                        state     <= S_BUSY;
                        exe.valid <= 1'b1;
                    end
                end
                default: begin
                    if (exe.ready) begin
                        exe.valid <= 1'b0;
                    end
                    if (retire.valid) begin
                        state <= S_IDLE;
                        pc    <= retire.next_pc; // Fetch resumes at the new pc.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exe.op_class <= cls;
            exe.funct3   <= word.r.funct3;
            exe.alt      <= word.r.funct7[5];
            exe.pc       <= pc;
            exe.rs1_val  <= rs1_val;
            exe.rs2_val  <= rs2_val;
            exe.imm      <= imm;
            exe.rd       <= word.r.rd;
        end
    end

endmodule

// ==== exec/exec_unit.sv ====
`timescale 1ns/1ps

module exec_unit (
    input  logic     clk,
    input  logic     rst_n,
    exec_if.exec     exe,
    mem_if.master    mem,
    retire_if.source retire
);

    localparam int XLEN = rv_pkg::XLEN;

    logic            take;
    logic            is_mem;
    logic            is_store;
    logic            taken;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] addr_sum;
    logic [XLEN-1:0] value_res;
    logic [XLEN-1:0] next_res;
    logic [4:0]      rd_res;

    assign exe.ready = exe.valid && !mem.req; // The mem request doubles as the busy flag.
    assign take      = exe.valid && exe.ready;
    assign is_store  = (exe.op_class == rv_pkg::CLS_STORE);
    assign is_mem    = is_store || (exe.op_class == rv_pkg::CLS_LOAD);

    assign op_b     = (exe.op_class == rv_pkg::CLS_ALU_REG) ? exe.rs2_val : exe.imm;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = exe.pc + 32'd4;
    assign pc_imm   = exe.pc + exe.imm;
    assign addr_sum = exe.rs1_val + exe.imm;

    always_comb begin
        case (exe.funct3)
            rv_pkg::F3_ADD: begin
                if (exe.op_class == rv_pkg::CLS_ALU_REG && exe.alt) begin
                    alu = exe.rs1_val - op_b;
                end else begin
                    alu = exe.rs1_val + op_b;
                end
            end
            rv_pkg::F3_SLL:  alu = exe.rs1_val << shamt;
            rv_pkg::F3_SLT:  alu = {31'b0, $signed(exe.rs1_val) < $signed(op_b)};
            rv_pkg::F3_SLTU: alu = {31'b0, exe.rs1_val < op_b};
            rv_pkg::F3_XOR:  alu = exe.rs1_val ^ op_b;
            rv_pkg::F3_SR:   alu = exe.alt ? XLEN'($signed(exe.rs1_val) >>> shamt)
                                           : exe.rs1_val >> shamt;
            rv_pkg::F3_OR:   alu = exe.rs1_val | op_b;
            default:         alu = exe.rs1_val & op_b;
        endcase
    end

    always_comb begin
        case (exe.funct3)
            rv_pkg::F3_BEQ:  taken = (exe.rs1_val == exe.rs2_val);
            rv_pkg::F3_BNE:  taken = (exe.rs1_val != exe.rs2_val);
            rv_pkg::F3_BLT:  taken = ($signed(exe.rs1_val) < $signed(exe.rs2_val));
            rv_pkg::F3_BGE:  taken = ($signed(exe.rs1_val) >= $signed(exe.rs2_val));
            rv_pkg::F3_BLTU: taken = (exe.rs1_val < exe.rs2_val);
            rv_pkg::F3_BGEU: taken = (exe.rs1_val >= exe.rs2_val);
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        value_res = '0;
        next_res  = pc_plus4;
        rd_res    = exe.rd;
        case (exe.op_class)
            rv_pkg::CLS_LUI:   value_res = exe.imm;
            rv_pkg::CLS_AUIPC: value_res = pc_imm;
            rv_pkg::CLS_JAL: begin
                value_res = pc_plus4;
                next_res  = pc_imm;
            end
            rv_pkg::CLS_JALR: begin
                value_res = pc_plus4;
                next_res  = {addr_sum[XLEN-1:1], 1'b0};
            end
            rv_pkg::CLS_BRANCH: begin
                rd_res = 5'd0;
                if (taken) begin
                    next_res = pc_imm;
                end
            end
            rv_pkg::CLS_ALU_IMM, rv_pkg::CLS_ALU_REG: value_res = alu;
            rv_pkg::CLS_LOAD: ;   // Value arrives with mem done.
            default: rd_res = 5'd0; // Stores and unknown opcodes write nothing.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem.req      <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= 1'b0;
            if (take) begin
                mem.req      <= is_mem;
                retire.valid <= !is_mem;
            end else if (mem.req && mem.done) begin
                mem.req      <= 1'b0;
                retire.valid <= 1'b1;
            end
        end
    end

    // The retire fields set at take stay put through a memory wait.
    always_ff @(posedge clk) begin
        if (take) begin
            retire.rd      <= rd_res;
            retire.value   <= value_res;
            retire.next_pc <= next_res;
            mem.addr       <= addr_sum;
            mem.we         <= is_store;
            mem.wdata      <= exe.rs2_val;
        end else if (mem.req && mem.done && !mem.we) begin
            retire.value <= mem.rdata;
        end
    end

endmodule

// ==== lsu/axil_data_port.sv ====
`timescale 1ns/1ps

module axil_data_port (
    input  logic                     clk,
    input  logic                     rst_n,
    mem_if.slave                     mem,
    output logic [rv_pkg::XLEN-1:0]  awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [rv_pkg::XLEN-1:0]  wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,   // Accepted and ignored.
    input  logic                     bvalid,
    output logic                     bready,
    output logic [rv_pkg::XLEN-1:0]  araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [rv_pkg::XLEN-1:0]  rdata,
    input  logic [1:0]               rresp,   // Accepted and ignored.
    input  logic                     rvalid,
    output logic                     rready
);

    typedef enum logic [1:0] {S_IDLE, S_WRITE, S_READ} state_e;

    state_e state;

    // Address and data are held by the requester until done.
    assign awaddr = mem.addr;
    assign araddr = mem.addr;
    assign wdata  = mem.wdata;
    assign wstrb  = 4'hf;
    assign bready = (state == S_WRITE);
    assign rready = (state == S_READ);

    assign mem.done  = (bready && bvalid) || (rready && rvalid);
    assign mem.rdata = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            arvalid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (mem.req && mem.we) begin
                        state   <= S_WRITE;
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else if (mem.req) begin
                        state   <= S_READ;
                        arvalid <= 1'b1;
                    end
                end
                S_WRITE: begin
                    if (awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic [rv_pkg::XLEN-1:0]  fetch_pc,
    input  logic [rv_pkg::XLEN-1:0]  instr,
    input  logic                     instr_valid,
    output logic                     instr_ready,
    output logic [rv_pkg::XLEN-1:0]  awaddr,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [rv_pkg::XLEN-1:0]  wdata,
    output logic [3:0]               wstrb,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic [1:0]               bresp,
    input  logic                     bvalid,
    output logic                     bready,
    output logic [rv_pkg::XLEN-1:0]  araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [rv_pkg::XLEN-1:0]  rdata,
    input  logic [1:0]               rresp,
    input  logic                     rvalid,
    output logic                     rready,
    output logic                     retire_valid,
    output logic [rv_pkg::XLEN-1:0]  retire_pc,
    output logic [4:0]               retire_rd,
    output logic [rv_pkg::XLEN-1:0]  retire_value
);

    exec_if   exe_ch ();
    mem_if    mem_ch ();
    retire_if ret_ch ();

    instr_decode #(
        .RESET_PC (RESET_PC)
    ) i_instr_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_pc    (fetch_pc),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .exe         (exe_ch),
        .retire      (ret_ch)
    );

    exec_unit i_exec_unit (
        .clk    (clk),
        .rst_n  (rst_n),
        .exe    (exe_ch),
        .mem    (mem_ch),
        .retire (ret_ch)
    );

    axil_data_port i_axil_data_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem     (mem_ch),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // The pc only moves at the edge that ends the retire beat.
    assign retire_pc    = fetch_pc;
    assign retire_valid = ret_ch.valid;
    assign retire_rd    = ret_ch.rd;
    assign retire_value = ret_ch.value;

endmodule

// ==== tests/rv_core_asserts.sv ====
`timescale 1ns/1ps

module rv_core_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       awvalid,
    input logic       awready,
    input logic       wvalid,
    input logic       wready,
    input logic       arvalid,
    input logic       arready,
    input logic       accept,
    input logic       ret_valid,
    input logic [4:0] ret_rd,
    input logic [3:0] op_class
);

    logic in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (accept) begin
            in_flight <= 1'b1;
        end else if (ret_valid) begin
            in_flight <= 1'b0;
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid) else $error("AWVALID dropped before AWREADY");
    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid) else $error("WVALID dropped before WREADY");
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid) else $error("ARVALID dropped before ARREADY");
    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight |-> !accept) else $error("Second instruction accepted before retire");
    a_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
        ret_valid && (op_class == rv_pkg::CLS_STORE || op_class == rv_pkg::CLS_BRANCH)
        |-> ret_rd == 5'd0) else $error("Store or branch retired with a nonzero rd");

endmodule

bind axil_data_port rv_core_asserts i_axil_asserts (
    .clk(clk), .rst_n(rst_n), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
    .wready(wready), .arvalid(arvalid), .arready(arready), .accept(1'b0),
    .ret_valid(1'b0), .ret_rd(5'd0), .op_class(4'd0)
);

bind instr_decode rv_core_asserts i_decode_asserts (
    .clk(clk), .rst_n(rst_n), .awvalid(1'b0), .awready(1'b0), .wvalid(1'b0),
    .wready(1'b0), .arvalid(1'b0), .arready(1'b0), .accept(instr_valid && instr_ready),
    .ret_valid(retire.valid), .ret_rd(retire.rd), .op_class(exe.op_class)
);

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [31:0] RESET_PC = 32'h40;

    logic clk, rst_n;
    logic [31:0] fetch_pc, instr, awaddr, wdata, araddr, rdata, retire_pc, retire_value;
    logic instr_valid, instr_ready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready, retire_valid;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic [4:0] retire_rd;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];   // Slave memory.
    logic [31:0] smem [256];   // Shadow memory.
    logic [31:0] sregs [32];
    logic [31:0] prog_pc, end_pc, exp_pc, aw_addr, w_data;
    logic aw_got, w_got, ar_got;
    integer seed;

    rv_core #(.RESET_PC(RESET_PC)) i_rv_core (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rnd(input int n);
        rnd = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] asm_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        rv_pkg::instr_word_u w;
        w.i = '{imm_11_0: imm, rs1: rs1, funct3: f3, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic logic [31:0] asm_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        rv_pkg::instr_word_u w;
        w.r = '{funct7: f7, rs2: rs2, rs1: rs1, funct3: f3, rd: rd, opcode: rv_pkg::OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] asm_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        rv_pkg::instr_word_u w;
        w.s = '{imm_11_5: imm[11:5], rs2: rs2, rs1: rs1, funct3: 3'b010,
                imm_4_0: imm[4:0], opcode: rv_pkg::OPC_STORE};
        return w;
    endfunction

    function automatic logic [31:0] asm_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        rv_pkg::instr_word_u w;
        w.b = '{imm_12: imm[12], imm_10_5: imm[10:5], rs2: rs2, rs1: rs1, funct3: f3,
                imm_4_1: imm[4:1], imm_11: imm[11], opcode: rv_pkg::OPC_BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] asm_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        rv_pkg::instr_word_u w;
        w.u = '{imm_31_12: imm, rd: rd, opcode: opc};
        return w;
    endfunction

    function automatic logic [31:0] asm_j(input logic [20:0] imm, input logic [4:0] rd);
        rv_pkg::instr_word_u w;
        w.j = '{imm_20: imm[20], imm_10_1: imm[10:1], imm_11: imm[11],
                imm_19_12: imm[19:12], rd: rd, opcode: rv_pkg::OPC_JAL};
        return w;
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[prog_pc[9:2]] = word;
        prog_pc = prog_pc + 32'd4;
    endtask

    // Computes the expected result of one instruction from the ISA field layout.
    function automatic void ref_exec(input logic [31:0] w, ref logic [31:0] regs [32],
                                     ref logic [31:0] mem [256], input logic [31:0] pc,
                                     output logic [4:0] rd, output logic [31:0] value,
                                     output logic [31:0] npc);
        logic [31:0] a, b, imm_i, addr;
        logic tk;
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        rd = w[11:7];
        value = '0;
        npc = pc + 32'd4;
        tk = 1'b0;
        case (w[6:0])
            rv_pkg::OPC_LUI:   value = {w[31:12], 12'b0};
            rv_pkg::OPC_AUIPC: value = pc + {w[31:12], 12'b0};
            rv_pkg::OPC_JAL: begin
                value = pc + 32'd4;
                npc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            rv_pkg::OPC_JALR: begin
                value = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            rv_pkg::OPC_BRANCH: begin
                rd = 5'd0;
                case (w[14:12])
                    3'b000: tk = (a == b);
                    3'b001: tk = (a != b);
                    3'b100: tk = ($signed(a) < $signed(b));
                    3'b101: tk = ($signed(a) >= $signed(b));
                    3'b110: tk = (a < b);
                    3'b111: tk = (a >= b);
                    default: tk = 1'b0;
                endcase
                if (tk) npc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP: begin
                if (w[6:0] == rv_pkg::OPC_OP_IMM) b = imm_i;
                case (w[14:12])
                    3'b000: value = (w[6:0] == rv_pkg::OPC_OP && w[30]) ? a - b : a + b;
                    3'b001: value = a << b[4:0];
                    3'b010: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b011: value = (a < b) ? 32'd1 : 32'd0;
                    3'b100: value = a ^ b;
                    3'b101: begin
                        if (w[30]) begin
                            value = $signed(a) >>> b[4:0];
                        end else begin
                            value = a >> b[4:0];
                        end
                    end
                    3'b110: value = a | b;
                    default: value = a & b;
                endcase
            end
            rv_pkg::OPC_LOAD: value = mem[(a + imm_i) >> 2 & 32'hff];
            rv_pkg::OPC_STORE: begin
                rd = 5'd0;
                mem[addr[9:2]] = b;
            end
            default: rd = 5'd0;  // Unknown opcodes retire as no-ops.
        endcase
        if (rd != 5'd0) regs[rd] = value;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        logic [4:0] sh;
        prog_pc = RESET_PC;
        for (int r = 1; r <= 8; r++) begin
            emit(asm_u(rnd(1 << 20), r, rv_pkg::OPC_LUI));
            emit(asm_i(rnd(4096), r, rv_pkg::F3_ADD, r, rv_pkg::OPC_OP_IMM));
        end
        emit(asm_u(20'h80000, 5'd9, rv_pkg::OPC_LUI));            // Most negative value.
        emit(asm_i(12'hfff, 5'd0, rv_pkg::F3_ADD, 5'd10, rv_pkg::OPC_OP_IMM));
        emit(asm_i(12'h123, 5'd1, rv_pkg::F3_ADD, 5'd0, rv_pkg::OPC_OP_IMM));
        // Random results go to x1 to x8 and leave the edge values in x9 and x10 intact.
        for (int k = 0; k < 2; k++) begin
            for (int f = 0; f < 8; f++) begin
                sh = rnd(32);
                emit(asm_i((f == 1 || f == 5) ? {7'b0, sh} : rnd(4096), rnd(11), f,
                           rnd(8) + 1, rv_pkg::OPC_OP_IMM));
                emit(asm_r(7'b0, rnd(11), rnd(11), f, rnd(8) + 1));
            end
            emit(asm_i({7'b0100000, 5'(rnd(32))}, rnd(11), rv_pkg::F3_SR, rnd(8) + 1,
                       rv_pkg::OPC_OP_IMM));
            emit(asm_r(7'b0100000, rnd(11), rnd(11), rv_pkg::F3_ADD, rnd(8) + 1));
            emit(asm_r(7'b0100000, rnd(11), rnd(11), rv_pkg::F3_SR, rnd(8) + 1));
            emit(asm_r(7'b0, 5'd10, 5'd9, rv_pkg::F3_SLT, 5'd13));
            emit(asm_r(7'b0, 5'd10, 5'd9, rv_pkg::F3_SLTU, 5'd14));
        end
        emit(asm_r(7'b0, 5'd0, 5'd2, rv_pkg::F3_ADD, 5'd15));     // Reads x0 after a write.
        emit(asm_u(rnd(1 << 20), 5'd11, rv_pkg::OPC_AUIPC));
        emit(asm_j(21'd8, 5'd12));
        emit(asm_i(12'h7ff, 5'd0, rv_pkg::F3_ADD, 5'd13, rv_pkg::OPC_OP_IMM));
        emit(asm_u(20'h0, 5'd5, rv_pkg::OPC_AUIPC));
        emit(asm_i(12'd13, 5'd5, 3'b000, 5'd6, rv_pkg::OPC_JALR));
        emit(asm_i(12'h7ff, 5'd0, rv_pkg::F3_ADD, 5'd13, rv_pkg::OPC_OP_IMM));
        emit(32'h0000_0f8b);                                       // Unknown opcode.
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            emit(asm_b(13'd8, 5'd1, 5'd1, f));
            emit(asm_i(12'd1, 5'd0, rv_pkg::F3_ADD, 5'd16, rv_pkg::OPC_OP_IMM));
            emit(asm_b(13'd8, 5'd10, 5'd9, f));
            emit(asm_i(12'd2, 5'd0, rv_pkg::F3_ADD, 5'd16, rv_pkg::OPC_OP_IMM));
            emit(asm_b(13'd8, 5'd9, 5'd10, f));
            emit(asm_i(12'd3, 5'd0, rv_pkg::F3_ADD, 5'd16, rv_pkg::OPC_OP_IMM));
        end
        for (int k = 0; k < 8; k++) begin
            emit(asm_i(rnd(256) * 4, 5'd0, rv_pkg::F3_ADD, 5'd20, rv_pkg::OPC_OP_IMM));
            emit(asm_s(12'd0, rnd(16), 5'd20));
            emit(asm_i(12'd0, 5'd20, 3'b010, rnd(8) + 21, rv_pkg::OPC_LOAD));
            emit(asm_i(12'd4, 5'd20, 3'b010, rnd(8) + 21, rv_pkg::OPC_LOAD));
        end
        end_pc = prog_pc;
    endtask

    // The fetch model raises valid after a random gap with the word for the published pc.
    always @(posedge clk) begin
        if (instr_valid && instr_ready) begin
            instr_valid <= 1'b0;
        end else if (!instr_valid && instr_ready && rnd(3) == 0) begin
            instr_valid <= 1'b1;
            instr <= imem[fetch_pc[9:2]];
        end
    end

    always @(posedge clk) begin
        awready <= awvalid && !awready && !aw_got && rnd(2) == 0;
        wready <= wvalid && !wready && !w_got && rnd(2) == 0;
        if (awvalid && awready) begin
            aw_got <= 1'b1;
            aw_addr <= awaddr;
        end
        if (wvalid && wready) begin
            w_got <= 1'b1;
            w_data <= wdata;
            check("wstrb", 32'h0000_000f, wstrb);
        end
        if (bvalid && bready) begin
            bvalid <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            dmem[aw_addr[9:2]] <= w_data;
        end else if (aw_got && w_got && !bvalid && rnd(3) == 0) begin
            bvalid <= 1'b1;
        end
        arready <= arvalid && !arready && !ar_got && rnd(2) == 0;
        if (arvalid && arready) begin
            ar_got <= 1'b1;
            rdata <= dmem[araddr[9:2]];
        end
        if (rvalid && rready) begin
            rvalid <= 1'b0;
            ar_got <= 1'b0;
        end else if (ar_got && !rvalid && rnd(3) == 0) begin
            rvalid <= 1'b1;
        end
    end

    always @(posedge clk) begin : check_retire
        logic [4:0] e_rd;
        logic [31:0] e_val, e_npc;
        if (rst_n && retire_valid) begin
            check("retire_pc", exp_pc, retire_pc);
            ref_exec(imem[exp_pc[9:2]], sregs, smem, exp_pc, e_rd, e_val, e_npc);
            check("retire_rd", e_rd, retire_rd);
            if (e_rd != 5'd0) check("retire_value", e_val, retire_value);
            exp_pc = e_npc;
        end
    end

    initial begin
        int cycles;
        seed = 32'h47cb;
        rst_n = 1'b0;
        {instr, instr_valid, awready, wready, bvalid, arready, rvalid, rdata} = '0;
        {bresp, rresp, aw_got, w_got, ar_got, aw_addr, w_data} = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = asm_i(12'd0, 5'd0, rv_pkg::F3_ADD, 5'd0, rv_pkg::OPC_OP_IMM);
            dmem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3} + i * 32'h0101_0101;
            smem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) sregs[i] = '0;
        build_program();
        exp_pc = RESET_PC;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("reset fetch_pc", RESET_PC, fetch_pc);
        check("reset instr_ready", 32'd0, instr_ready);
        cycles = 0;
        while (exp_pc != end_pc && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_pc != end_pc) begin
            $display("Timeout: the program did not retire to its end address in time.");
            $display("SIMULATION FAILED");
            $fatal(1);
        end else begin
            for (int i = 0; i < 256; i++) begin
                check("data memory", smem[i], dmem[i]);
            end
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
common/rv_pkg.sv
common/core_ifs.sv
decode/reg_file.sv
decode/instr_decode.sv
exec/exec_unit.sv
lsu/axil_data_port.sv
src/rv_core.sv
tests/rv_core_asserts.sv
tests/tb_rv_core.sv
